//--- hdl/dw_pkg.sv
package dw_pkg;

  localparam int BITS_KW2       = 2;  // Half kernel width index.
  localparam int BITS_SW        = 2;  // Stride minus one.
  localparam int BITS_MEMBERS   = 4;  // Serializer step count.
  localparam int BITS_OUT_SHIFT = 2;  // Selector output count.
  localparam int CLR_WIDTH      = 3;  // Clear code per column.
  localparam int TAG_WIDTH      = 8;  // Opaque tag, passed through.

  // Carried with every step and every output beat.
  typedef struct packed {
    logic [BITS_KW2-1:0]  kw2;
    logic [BITS_SW-1:0]   sw_1;
    logic [TAG_WIDTH-1:0] tag;
  } dw_base_t;

  // Input user word.
  typedef struct packed {
    logic [BITS_MEMBERS-1:0]   shift_a;
    logic [BITS_OUT_SHIFT-1:0] shift_b;
    dw_base_t                  base;
  } dw_cfg_t;

  // Output user word.
  typedef struct packed {
    logic [CLR_WIDTH-1:0] clr;
    dw_base_t             base;
  } dw_out_user_t;

endpackage

//--- hdl/dw_column_serializer.sv
`timescale 1ns/1ps

module dw_column_serializer
  import dw_pkg::*;
#(
  parameter int ROWS       = 2,
  parameter int COLS       = 12,
  parameter int WORD_WIDTH = 16
) (
  input  logic                                           aclk,
  input  logic                                           rst,
  input  logic                                           s_valid,
  output logic                                           s_ready,
  input  logic                                           s_last,
  input  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0]      s_data,
  input  logic [COLS-1:0][CLR_WIDTH-1:0]                 s_clr,
  input  dw_cfg_t                                        s_cfg,
  input  logic                                           step_ready,
  output logic                                           step_valid,
  output logic [COLS-1:0][ROWS*WORD_WIDTH+CLR_WIDTH-1:0] step_cols,
  output dw_base_t                                       step_base,
  output logic                                           step_last,
  output logic [BITS_OUT_SHIFT-1:0]                      step_shift_b
);

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] data;
    logic [CLR_WIDTH-1:0]            clr;
  } col_t;

  col_t [COLS-1:0]           col_q;
  col_t [COLS-1:0]           col_load;
  logic [BITS_MEMBERS-1:0]   count_q;
  logic                      count_zero;
  logic                      count_en;
  logic                      accept;
  logic                      valid_q;
  logic                      last_q;
  dw_base_t                  base_q;
  logic [BITS_OUT_SHIFT-1:0] shift_b_q;

  assign count_zero = (count_q == '0);
  assign count_en   = step_ready & (count_zero ? s_valid : 1'b1);
  assign s_ready    = step_ready & count_zero;  // New beat only after the last step.
  assign accept     = s_valid & s_ready;

  always_comb begin
    for (int m = 0; m < COLS; m++) begin
      col_load[m].data = s_data[m];
      col_load[m].clr  = s_clr[m];
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      count_q <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      if (count_en) begin
        count_q <= count_zero ? s_cfg.shift_a : count_q - 1'b1;
      end
      if (s_ready) begin
        valid_q <= s_valid;  // Drops once the final step is taken with no new beat.
      end
      if (accept) begin
        last_q <= s_last;
      end
    end
  end

  // Column m moves to m+1 on every step, zero fills from the bottom.
  always_ff @(posedge aclk) begin
    if (count_en) begin
      if (count_zero) begin
        col_q <= col_load;
      end else begin
        col_q <= {col_q[COLS-2:0], col_t'('0)};
      end
    end
    if (accept) begin
      base_q    <= s_cfg.base;
      shift_b_q <= s_cfg.shift_b;
    end
  end

  assign step_valid   = valid_q;
  assign step_cols    = col_q;
  assign step_base    = base_q;
  assign step_last    = last_q & count_zero;
  assign step_shift_b = shift_b_q;

endmodule

//--- hdl/dw_stride_selector.sv
`timescale 1ns/1ps

module dw_stride_selector
  import dw_pkg::*;
#(
  parameter int ROWS       = 2,
  parameter int COLS       = 12,
  parameter int WORD_WIDTH = 16,
  parameter int KW_MAX     = 5,
  parameter int SW_MAX     = 3
) (
  input  logic                                           aclk,
  input  logic                                           rst,
  input  logic                                           step_valid,
  output logic                                           step_ready,
  input  logic [COLS-1:0][ROWS*WORD_WIDTH+CLR_WIDTH-1:0] step_cols,
  input  dw_base_t                                       step_base,
  input  logic                                           step_last,
  input  logic [BITS_OUT_SHIFT-1:0]                      step_shift_b,
  output logic                                           o_valid,
  input  logic                                           o_ready,
  output logic [ROWS-1:0][WORD_WIDTH-1:0]                o_data,
  output dw_out_user_t                                   o_user,
  output logic                                           o_last
);

  localparam int SLOTS   = COLS / 3;
  localparam int KW2_TOP = KW_MAX / 2;

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] data;
    logic [CLR_WIDTH-1:0]            clr;
  } col_t;

  col_t [COLS-1:0]           cols_in;
  wire  [SLOTS-1:0][ROWS*WORD_WIDTH+CLR_WIDTH-1:0] col_mux [KW2_TOP+1][SW_MAX];
  col_t [SLOTS-1:0]          slot_sel;
  col_t [SLOTS-1:0]          slot_q;
  logic [BITS_OUT_SHIFT-1:0] count_q;
  logic                      count_zero;
  logic                      count_en;
  logic                      valid_q;
  logic                      last_q;
  dw_base_t                  base_q;

  assign cols_in = step_cols;

  // One fixed column pick per kernel/stride pair.
  for (genvar kw = 0; kw <= KW2_TOP; kw++) begin : g_kw
    for (genvar sw = 0; sw < SW_MAX; sw++) begin : g_sw
      for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        localparam int J   = 2 * kw + 1 + sw;
        localparam int IDX = (kw == 0) ? ((i == 0) ? COLS - 1 : -1) : i * J + J - 1;
        if (IDX >= 0 && IDX < COLS) begin : g_on
          assign col_mux[kw][sw][i] = cols_in[IDX];
        end else begin : g_off
          assign col_mux[kw][sw][i] = '0;
        end
      end
    end
  end

  always_comb begin
    slot_sel = '0;
    for (int kw = 0; kw <= KW2_TOP; kw++) begin
      for (int sw = 0; sw < SW_MAX; sw++) begin
        if (int'(step_base.kw2) == kw && int'(step_base.sw_1) == sw) begin
          slot_sel = col_mux[kw][sw];
        end
      end
    end
  end

  assign count_zero = (count_q == '0);
  assign count_en   = o_ready & (count_zero ? step_valid : 1'b1);
  assign step_ready = o_ready & count_zero;

  always_ff @(posedge aclk) begin
    if (rst) begin
      count_q <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      if (count_en) begin
        count_q <= count_zero ? step_shift_b : count_q - 1'b1;
      end
      if (step_ready) begin
        valid_q <= step_valid;
      end
      if (step_valid && step_ready) begin
        last_q <= step_last;
      end
    end
  end

  // Slot 0 is the current output; the rest move down one per beat.
  always_ff @(posedge aclk) begin
    if (count_en) begin
      if (count_zero) begin
        slot_q <= slot_sel;
      end else begin
        slot_q <= {col_t'('0), slot_q[SLOTS-1:1]};
      end
    end
    if (step_valid && step_ready) begin
      base_q <= step_base;
    end
  end

  assign o_valid     = valid_q;
  assign o_data      = slot_q[0].data;
  assign o_user.clr  = slot_q[0].clr;
  assign o_user.base = base_q;
  assign o_last      = last_q & count_zero;

endmodule

//--- hdl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             aclk,
  input  logic             rst,
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  logic [WIDTH-1:0] main_q;
  logic [WIDTH-1:0] skid_q;
  logic             main_valid_q;
  logic             skid_empty_q;
  logic             main_free;

  assign main_free = m_ready | ~main_valid_q;

  always_ff @(posedge aclk) begin
    if (rst) begin
      main_valid_q <= 1'b0;
      skid_empty_q <= 1'b1;
    end else if (skid_empty_q) begin
      if (main_free) begin
        main_valid_q <= s_valid;
      end else if (s_valid) begin
        skid_empty_q <= 1'b0;  // Output stalled, park the beat.
      end
    end else if (m_ready) begin
      skid_empty_q <= 1'b1;  // Skid moves to main, main stays valid.
    end
  end

  always_ff @(posedge aclk) begin
    if (skid_empty_q) begin
      if (s_valid && main_free) begin
        main_q <= s_data;
      end
      if (s_valid && !main_free) begin
        skid_q <= s_data;
      end
    end else if (m_ready) begin
      main_q <= skid_q;
    end
  end

  assign s_ready = skid_empty_q;
  assign m_valid = main_valid_q;
  assign m_data  = main_q;

endmodule

//--- hdl/dw_conv_shift.sv
`timescale 1ns/1ps

module dw_conv_shift
  import dw_pkg::*;
#(
  parameter int ROWS       = 2,
  parameter int COLS       = 12,
  parameter int WORD_WIDTH = 16,
  parameter int KW_MAX     = 5,
  parameter int SW_MAX     = 3
) (
  input  logic                                      aclk,
  input  logic                                      rst,
  input  logic                                      s_valid,
  output logic                                      s_ready,
  input  logic                                      s_last,
  input  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data,
  input  logic [COLS-1:0][CLR_WIDTH-1:0]            s_clr,
  input  dw_cfg_t                                   s_cfg,
  output logic                                      m_valid,
  input  logic                                      m_ready,
  output logic                                      m_last,
  output logic [ROWS-1:0][WORD_WIDTH-1:0]           m_data,
  output dw_out_user_t                              m_user
);

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] data;
    dw_out_user_t                    user;
    logic                            last;
  } out_beat_t;

  logic                                           step_valid;
  logic                                           step_ready;
  logic [COLS-1:0][ROWS*WORD_WIDTH+CLR_WIDTH-1:0] step_cols;
  dw_base_t                                       step_base;
  logic                                           step_last;
  logic [BITS_OUT_SHIFT-1:0]                      step_shift_b;
  logic                                           o_valid;
  logic                                           o_ready;
  out_beat_t                                      o_beat;
  out_beat_t                                      m_beat;

  dw_column_serializer #(
    .ROWS         (ROWS),
    .COLS         (COLS),
    .WORD_WIDTH   (WORD_WIDTH)
  ) serializer0 (
    .aclk         (aclk),
    .rst          (rst),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .s_last       (s_last),
    .s_data       (s_data),
    .s_clr        (s_clr),
    .s_cfg        (s_cfg),
    .step_ready   (step_ready),
    .step_valid   (step_valid),
    .step_cols    (step_cols),
    .step_base    (step_base),
    .step_last    (step_last),
    .step_shift_b (step_shift_b)
  );

  dw_stride_selector #(
    .ROWS         (ROWS),
    .COLS         (COLS),
    .WORD_WIDTH   (WORD_WIDTH),
    .KW_MAX       (KW_MAX),
    .SW_MAX       (SW_MAX)
  ) selector0 (
    .aclk         (aclk),
    .rst          (rst),
    .step_valid   (step_valid),
    .step_ready   (step_ready),
    .step_cols    (step_cols),
    .step_base    (step_base),
    .step_last    (step_last),
    .step_shift_b (step_shift_b),
    .o_valid      (o_valid),
    .o_ready      (o_ready),
    .o_data       (o_beat.data),
    .o_user       (o_beat.user),
    .o_last       (o_beat.last)
  );

  skid_buffer #(
    .WIDTH   ($bits(out_beat_t))
  ) skid0 (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (o_valid),
    .s_ready (o_ready),
    .s_data  (o_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_beat)
  );

  assign m_data = m_beat.data;
  assign m_user = m_beat.user;
  assign m_last = m_beat.last;

endmodule

//--- testbench/dw_conv_shift_checker.sv
`timescale 1ns/1ps

module dw_conv_shift_checker
  import dw_pkg::*;
#(
  parameter int ROWS       = 2,
  parameter int WORD_WIDTH = 16
) (
  input logic                            aclk,
  input logic                            rst,
  input logic                            m_valid,
  input logic                            m_ready,
  input logic                            m_last,
  input logic [ROWS-1:0][WORD_WIDTH-1:0] m_data,
  input dw_out_user_t                    m_user
);

  int fail_count = 0;  // Read by the testbench at the end of the run.

  reset_idle: assert property (@(posedge aclk) rst |=> !m_valid)
    else begin
      $error("m_valid high in the cycle after reset");
      fail_count++;
    end

  hold_stable: assert property (@(posedge aclk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable({m_data, m_user, m_last}))
    else begin
      $error("output beat changed or dropped while m_ready was low");
      fail_count++;
    end

  no_unknown: assert property (@(posedge aclk) disable iff (rst)
    m_valid |-> !$isunknown({m_data, m_user, m_last}))
    else begin
      $error("unknown bits on the output while m_valid is high");
      fail_count++;
    end

endmodule

//--- testbench/dw_conv_shift_tb.sv
`timescale 1ns/1ps

module dw_conv_shift_tb
  import dw_pkg::*;
();

  localparam int ROWS       = 2;
  localparam int COLS       = 12;
  localparam int WORD_WIDTH = 16;
  localparam int KW_MAX     = 5;
  localparam int SW_MAX     = 3;
  localparam int TIMEOUT    = 2000;  // Cycles per wait.

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] data;
    dw_out_user_t                    user;
    logic                            last;
  } beat_t;

  logic                                      aclk = 1'b0;
  logic                                      rst;
  logic                                      s_valid;
  logic                                      s_ready;
  logic                                      s_last;
  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data;
  logic [COLS-1:0][CLR_WIDTH-1:0]            s_clr;
  dw_cfg_t                                   s_cfg;
  logic                                      m_valid;
  logic                                      m_ready;
  logic                                      m_last;
  logic [ROWS-1:0][WORD_WIDTH-1:0]           m_data;
  dw_out_user_t                              m_user;

  beat_t       exp_q[$];
  logic [31:0] stim_state  = 32'd5;
  logic [31:0] ready_state = 32'd5;
  logic [31:0] saved_state;
  logic        bp_on       = 1'b0;
  string       test_name   = "reset";
  int          errors      = 0;
  int          checks      = 0;
  int          accepted    = 0;
  int          pushed      = 0;
  int          out_beats   = 0;
  int          last_in     = 0;
  int          last_out    = 0;

  always #2 aclk = ~aclk;

  dw_conv_shift #(
    .ROWS(ROWS), .COLS(COLS), .WORD_WIDTH(WORD_WIDTH), .KW_MAX(KW_MAX), .SW_MAX(SW_MAX)
  ) dut0 (.*);

  bind dw_conv_shift dw_conv_shift_checker #(.ROWS(ROWS), .WORD_WIDTH(WORD_WIDTH)) chk0 (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int pick(input int n);
    stim_state = lcg_step(stim_state);
    return int'(stim_state[31:16]) % n;
  endfunction

  // Expected output beats of one accepted input in step order.
  task automatic push_expected(input logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] data,
                               input logic [COLS-1:0][CLR_WIDTH-1:0] clr,
                               input dw_cfg_t cfg, input logic last);
    beat_t b;
    int    j;
    int    idx;
    for (int t = 0; t <= int'(cfg.shift_a); t++) begin
      for (int i = 0; i <= int'(cfg.shift_b); i++) begin
        if (cfg.base.kw2 == '0) begin
          idx = (i == 0) ? COLS - 1 : -1;
        end else begin
          j   = 2 * int'(cfg.base.kw2) + 1 + int'(cfg.base.sw_1);
          idx = i * j + j - 1;
        end
        b = '0;
        if (idx >= t && idx < COLS) begin  // Below t the register is zero filled.
          b.data     = data[idx-t];
          b.user.clr = clr[idx-t];
        end
        b.user.base = cfg.base;
        b.last      = last && t == int'(cfg.shift_a) && i == int'(cfg.shift_b);
        exp_q.push_back(b);
        pushed++;
      end
    end
  endtask

  always @(posedge aclk) begin
    beat_t got;
    if (!rst && s_valid && s_ready) begin
      push_expected(s_data, s_clr, s_cfg, s_last);
      accepted++;
      if (s_last) last_in++;
    end
    if (!rst && m_valid && m_ready) begin
      got.data = m_data;
      got.user = m_user;
      got.last = m_last;
      out_beats++;
      if (m_last) last_out++;
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("unexpected output beat in %s while the model queue is empty", test_name);
        errors++;
      end
      if (exp_q.size() != 0) begin
        assert (got == exp_q[0]) else begin
          $display("MISMATCH %s expected %h actual %h", test_name, exp_q[0], got);
          errors++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(negedge aclk) begin
    ready_state = lcg_step(ready_state);
    m_ready = !bp_on || ready_state[31:30] != 2'b00;  // About one stall in four.
  end

  // Called on a falling edge and returns on the falling edge after acceptance.
  task automatic send_random(input logic pass_mode);
    int start;
    int waited;
    repeat (pick(4)) @(negedge aclk);
    for (int m = 0; m < COLS; m++) begin
      for (int r = 0; r < ROWS; r++) s_data[m][r] = WORD_WIDTH'(pick(65536));
      s_clr[m] = CLR_WIDTH'(pick(8));
    end
    s_cfg           = '0;
    s_cfg.base.tag  = TAG_WIDTH'(pick(256));
    if (!pass_mode) begin
      s_cfg.base.kw2  = BITS_KW2'(pick(KW_MAX / 2 + 1));
      s_cfg.base.sw_1 = BITS_SW'(pick(SW_MAX));
      s_cfg.shift_a   = BITS_MEMBERS'(pick(16));
      s_cfg.shift_b   = BITS_OUT_SHIFT'(pick(4));
    end
    s_last  = pick(2) == 0;
    s_valid = 1'b1;
    start   = accepted;
    waited  = 0;
    while (accepted == start && waited < TIMEOUT) begin
      @(negedge aclk);
      waited++;
    end
    s_valid = 1'b0;
    if (accepted == start) begin
      $display("timeout in %s, an input beat was never accepted", test_name);
      errors++;
    end
  endtask

  task automatic drain();
    int waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge aclk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout in %s, %0d expected beats never arrived", test_name, exp_q.size());
      errors++;
    end
  endtask

  task automatic run_test(input string name, input int n, input logic pass_mode, input logic bp);
    int err0 = errors;
    int out0 = out_beats;
    int push0 = pushed;
    int lin0 = last_in;
    int lout0 = last_out;
    test_name = name;
    bp_on     = bp;
    repeat (n) send_random(pass_mode);
    drain();
    checks += 2;
    assert (out_beats - out0 == pushed - push0) else begin
      $display("MISMATCH %s beat count expected %0d actual %0d", name, pushed - push0,
               out_beats - out0);
      errors++;
    end
    assert (last_out - lout0 == last_in - lin0) else begin
      $display("MISMATCH %s last count expected %0d actual %0d", name, last_in - lin0,
               last_out - lout0);
      errors++;
    end
    $display("test %s done, %0d beats, %0d errors", name, out_beats - out0, errors - err0);
  endtask

  initial begin
    int out0;
    rst     = 1'b1;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    s_clr   = '0;
    s_cfg   = '0;
    m_ready = 1'b1;
    repeat (3) @(negedge aclk);
    rst = 1'b0;
    @(negedge aclk);
    checks++;
    assert (!m_valid && s_ready) else begin
      $display("MISMATCH %s expected m_valid 0 s_ready 1 actual m_valid %b s_ready %b",
               test_name, m_valid, s_ready);
      errors++;
    end
    $display("test reset done, %0d errors", errors);
    run_test("passthrough", 8, 1'b1, 1'b0);
    saved_state = stim_state;
    run_test("random_full", 40, 1'b0, 1'b0);
    stim_state = saved_state;  // Same beats again under back-pressure.
    run_test("random_backpressure", 40, 1'b0, 1'b1);
    run_test("last_flag", 20, 1'b0, 1'b1);
    test_name = "drain";
    bp_on     = 1'b0;
    drain();
    out0 = out_beats;
    repeat (30) @(negedge aclk);
    checks += 2;
    assert (out_beats == out0) else begin
      $display("extra output beats appeared after the drain");
      errors++;
    end
    assert (s_ready) else begin
      $display("MISMATCH %s s_ready expected 1 actual %b", test_name, s_ready);
      errors++;
    end
    $display("test drain done, queue size %0d", exp_q.size());
    errors += dut0.chk0.fail_count;
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- dw_conv_shift.f
hdl/dw_pkg.sv
hdl/dw_column_serializer.sv
hdl/dw_stride_selector.sv
hdl/skid_buffer.sv
hdl/dw_conv_shift.sv
testbench/dw_conv_shift_checker.sv
testbench/dw_conv_shift_tb.sv
